// ==== Makefile ====
# Verilator build for the taskwait manager testbench

VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert -Wno-fatal
PASS_MSG  ?= >>> PASS

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

# the run passes only if the pass message shows up as a line of its own
sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -xF '$(PASS_MSG)' > /dev/null

clean:
	rm -rf $(OBJ_DIR)

// ==== sources.f ====
+incdir+.
tw_pkg.sv
tw_msg_if.sv
tw_msg_decoder.sv
tw_table_ram.sv
tw_engine.sv
tw_top.sv
tb_top.sv

// ==== tb_top.sv ====
// directed testbench for tw_top; the engine clears its table after reset, and the test ids never fill it
`timescale 1ns/100ps
`include "tw_defines.svh"

module tb_top import tw_pkg::*; ();

    localparam int READY_TIMEOUT = 200;
    localparam int WAKE_TIMEOUT  = 200;

    logic     clk;
    logic     rstn;
    task_id_t wait_data;
    logic     wait_valid;
    logic     wait_ready;
    acc_id_t  wait_src;
    task_id_t fin_data;
    logic     fin_valid;
    logic     fin_ready;
    acc_id_t  fin_src;
    logic     wake_valid;
    logic     wake_ready;
    acc_id_t  wake_dest;

    int seed = 5;
    int errors = 0;
    int checks = 0;
    int tests = 0;

    tw_top dut (
        .clk        (clk),
        .rstn       (rstn),
        .wait_data  (wait_data),
        .wait_valid (wait_valid),
        .wait_ready (wait_ready),
        .wait_src   (wait_src),
        .fin_data   (fin_data),
        .fin_valid  (fin_valid),
        .fin_ready  (fin_ready),
        .fin_src    (fin_src),
        .wake_valid (wake_valid),
        .wake_ready (wake_ready),
        .wake_dest  (wake_dest)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // the header holds the code in 63:56, the type in bit 32 with 1 for a taskwait
    // and the component count in 31:0
    function automatic task_id_t make_header(input logic [7:0] code, input logic is_wait,
                                             input comp_t comp);
        task_id_t hdr;
        hdr = '0;
        hdr[`TW_CODE_H:`TW_CODE_L] = code;
        hdr[`TW_TYPE_BIT] = is_wait;
        hdr[`TW_COMP_H:`TW_COMP_L] = comp;
        return hdr;
    endfunction

    function automatic task_id_t random_tid();
        task_id_t tid;
        tid = {$random(seed), $random(seed)};
        return tid;
    endfunction

    task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
        checks++;
        if (exp !== act) begin
            $display("CHECK FAILED %s: expected %0h, actual %0h", name, exp, act);
            errors++;
        end
    endtask

    // all driver tasks start and end 1 ns after a rising edge
    task automatic send_wait(input task_id_t tid, input comp_t comp, input acc_id_t src,
                             input logic [7:0] code);
        task_id_t beats [2];
        int waited;
        beats[0] = make_header(code, 1'b1, comp);
        beats[1] = tid;
        for (int i = 0; i < 2; i++) begin
            wait_data  = beats[i];
            wait_src   = src;
            wait_valid = 1'b1;
            waited     = 0;
            while (!wait_ready && waited < READY_TIMEOUT) begin
                @(posedge clk);
                #1;
                waited++;
            end
            if (!wait_ready) begin
                $display("timeout: taskwait stream never became ready");
                errors++;
                wait_valid = 1'b0;
                return;
            end
            @(posedge clk);
            #1;
        end
        wait_valid = 1'b0;
    endtask

    task automatic send_fin(input task_id_t tid, input acc_id_t src);
        task_id_t beats [2];
        int waited;
        beats[0] = make_header(`TW_MSG_CODE, 1'b0, comp_t'(0));
        beats[1] = tid;
        for (int i = 0; i < 2; i++) begin
            fin_data  = beats[i];
            fin_src   = src;
            fin_valid = 1'b1;
            waited    = 0;
            while (!fin_ready && waited < READY_TIMEOUT) begin
                @(posedge clk);
                #1;
                waited++;
            end
            if (!fin_ready) begin
                $display("timeout: finish stream never became ready");
                errors++;
                fin_valid = 1'b0;
                return;
            end
            @(posedge clk);
            #1;
        end
        fin_valid = 1'b0;
    endtask

    task automatic wait_wake_valid(input string name, output logic seen);
        int waited;
        waited = 0;
        while (!wake_valid && waited < WAKE_TIMEOUT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        seen = wake_valid;
        if (!seen) begin
            $display("timeout in %s: no wake-up arrived", name);
            errors++;
        end
    endtask

    task automatic wait_wake_done(input string name);
        int waited;
        waited = 0;
        while (wake_valid && waited < WAKE_TIMEOUT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (wake_valid) begin
            $display("timeout in %s: wake-up never completed", name);
            errors++;
        end
    endtask

    task automatic expect_wake(input string name, input acc_id_t dest);
        logic seen;
        wait_wake_valid(name, seen);
        if (seen) begin
            check_val(name, 64'(dest), 64'(wake_dest));
            wait_wake_done(name);
        end
    endtask

    task automatic expect_no_wake(input string name);
        for (int i = 0; i < 60; i++) begin
            @(posedge clk);
            #1;
            if (wake_valid) begin
                $display("unexpected wake-up to %0d in %s", wake_dest, name);
                errors++;
                break;
            end
        end
    endtask

    task automatic report_test(input string name, input int err_start);
        tests++;
        if (errors == err_start) begin
            $display("test %s finished ok", name);
        end else begin
            $display("test %s finished with %0d errors", name, errors - err_start);
        end
    endtask

    task automatic test_zero_wait();
        int err_start;
        task_id_t tid;
        err_start = errors;
        tid = random_tid();
        send_wait(tid, comp_t'(0), acc_id_t'(3), `TW_MSG_CODE);
        expect_wake("zero_wait", acc_id_t'(3));
        // nothing was allocated, so this finish opens an entry with count 1
        send_fin(tid, acc_id_t'(6));
        expect_no_wake("zero_wait");
        report_test("zero_wait", err_start);
    endtask

    task automatic test_count_down();
        int err_start;
        task_id_t tid;
        err_start = errors;
        tid = random_tid();
        send_wait(tid, comp_t'(3), acc_id_t'(5), `TW_MSG_CODE);
        expect_no_wake("count_down");
        for (int i = 0; i < 2; i++) begin
            send_fin(tid, acc_id_t'(12));
            expect_no_wake("count_down");
        end
        send_fin(tid, acc_id_t'(12));
        expect_wake("count_down", acc_id_t'(5));
        report_test("count_down", err_start);
    endtask

    task automatic test_finish_first();
        int err_start;
        task_id_t tid;
        err_start = errors;
        tid = random_tid();
        send_fin(tid, acc_id_t'(14));
        send_fin(tid, acc_id_t'(14));
        expect_no_wake("finish_first");
        send_wait(tid, comp_t'(2), acc_id_t'(7), `TW_MSG_CODE);
        expect_wake("finish_first", acc_id_t'(7));
        expect_no_wake("finish_first");
        report_test("finish_first", err_start);
    endtask

    task automatic test_interleave();
        int err_start;
        task_id_t tid_a;
        task_id_t tid_b;
        err_start = errors;
        tid_a = random_tid();
        tid_b = random_tid();
        // both streams deliver at once, so the engine has to arbitrate
        fork
            send_wait(tid_a, comp_t'(2), acc_id_t'(1), `TW_MSG_CODE);
            send_fin(tid_b, acc_id_t'(8));
        join
        expect_no_wake("interleave");
        fork
            send_fin(tid_a, acc_id_t'(8));
            send_wait(tid_b, comp_t'(1), acc_id_t'(2), `TW_MSG_CODE);
        join
        expect_wake("interleave", acc_id_t'(2));
        expect_no_wake("interleave");
        send_fin(tid_a, acc_id_t'(8));
        expect_wake("interleave", acc_id_t'(1));
        expect_no_wake("interleave");
        report_test("interleave", err_start);
    endtask

    task automatic test_bad_code();
        int err_start;
        task_id_t tid;
        err_start = errors;
        tid = random_tid();
        send_wait(tid, comp_t'(1), acc_id_t'(4), 8'h5A);
        expect_no_wake("bad_code");
        // had the taskwait been kept, this finish would bring the count to zero
        send_fin(tid, acc_id_t'(10));
        expect_no_wake("bad_code");
        report_test("bad_code", err_start);
    endtask

    task automatic test_backpressure();
        int err_start;
        logic seen;
        task_id_t tid;
        task_id_t tid_fin;
        task_id_t tid_wait;
        err_start = errors;
        tid = random_tid();
        tid_fin = random_tid();
        tid_wait = random_tid();
        wake_ready = 1'b0;
        send_wait(tid, comp_t'(0), acc_id_t'(9), `TW_MSG_CODE);
        wait_wake_valid("backpressure", seen);
        if (seen) begin
            // the stalled engine takes nothing, so both decoders fill and stall their streams
            fork
                send_fin(tid_fin, acc_id_t'(11));
                send_wait(tid_wait, comp_t'(1), acc_id_t'(13), `TW_MSG_CODE);
                for (int i = 0; i < 20; i++) begin
                    @(posedge clk);
                    #1;
                    check_val("backpressure", 64'(1), 64'(wake_valid));
                    check_val("backpressure", 64'(acc_id_t'(9)), 64'(wake_dest));
                end
            join
            check_val("backpressure", 64'(0), 64'(fin_ready));
            check_val("backpressure", 64'(0), 64'(wait_ready));
        end
        wake_ready = 1'b1;
        wait_wake_done("backpressure");
        // the held finish and taskwait open new entries and wake nobody
        expect_no_wake("backpressure");
        report_test("backpressure", err_start);
    endtask

    initial begin
        rstn       = 1'b0;
        wait_data  = '0;
        wait_valid = 1'b0;
        wait_src   = '0;
        fin_data   = '0;
        fin_valid  = 1'b0;
        fin_src    = '0;
        wake_ready = 1'b1;
        repeat (4) @(posedge clk);
        #1;
        rstn = 1'b1;
        test_zero_wait();
        test_count_down();
        test_finish_first();
        test_interleave();
        test_bad_code();
        test_backpressure();
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== tw_defines.svh ====
// table depth and field positions are fixed at compile time; the table word layout must match TW_WORD_W
`ifndef TW_DEFINES_SVH
`define TW_DEFINES_SVH

// table size and accelerator id width
`define TW_ENTRIES 16
`define TW_ACC_BITS 4

// header word of a stream message
`define TW_MSG_CODE 8'hA7
`define TW_CODE_H 63
`define TW_CODE_L 56
`define TW_TYPE_BIT 32
`define TW_COMP_H 31
`define TW_COMP_L 0

// one table word is valid, accelerator id, signed pending count and task id
`define TW_WORD_W 101
`define TW_VALID_B 100
`define TW_ACC_L 96
`define TW_CNT_H 95
`define TW_CNT_L 64
`define TW_TID_H 63
`define TW_TID_L 0

`endif

// ==== tw_engine.sv ====
// table full is not handled: an allocation with no free entry overwrites an entry and is only flagged
`timescale 1ns/100ps
`include "tw_defines.svh"

module tw_engine import tw_pkg::*; (
    input  logic     clk,
    input  logic     rstn,
    tw_msg_if.dst    wait_msg,
    tw_msg_if.dst    fin_msg,
    output logic     tab_en,
    output logic     tab_we,
    output tw_idx_t  tab_addr,
    output tw_word_t tab_din,
    input  tw_word_t tab_dout,
    output logic     wake_valid,
    input  logic     wake_ready,
    output acc_id_t  wake_dest
);

    localparam tw_idx_t LAST_IDX = tw_idx_t'(`TW_ENTRIES - 1);

    tw_state_t state;
    logic      clr_started;
    logic      clr_busy;
    tw_idx_t   clr_idx;
    logic      last_wait;
    logic      pick_wait;
    logic      start;
    logic      req_wait;
    comp_t     req_comp;
    task_id_t  req_tid;
    acc_id_t   req_acc;
    tw_idx_t   scan_idx;
    tw_idx_t   free_idx;
    logic      free_found;
    logic      found;
    comp_t     ent_cnt;
    acc_id_t   ent_acc;
    logic      dout_match;
    comp_t     new_cnt;
    acc_id_t   entry_acc;
    logic      imm_wake;
    logic      cnt_zero;

    // alternate when both decoders hold a message, taskwait first after reset
    assign pick_wait = wait_msg.msg_valid && (!fin_msg.msg_valid || !last_wait);
    assign start = state == IDLE && clr_started && !clr_busy
                   && (wait_msg.msg_valid || fin_msg.msg_valid);
    assign wait_msg.msg_take = start && pick_wait;
    assign fin_msg.msg_take  = start && !pick_wait;

    assign dout_match = tab_dout[`TW_VALID_B] && tab_dout[`TW_TID_H:`TW_TID_L] == req_tid;

    always_comb begin
        if (found) begin
            new_cnt = req_wait ? ent_cnt - req_comp : ent_cnt + comp_t'(1);
        end else begin
            new_cnt = req_wait ? comp_t'(0) - req_comp : comp_t'(1);
        end
    end

    // a taskwait with nothing outstanding needs no entry at all
    assign imm_wake  = !found && req_wait && req_comp == '0;
    assign cnt_zero  = found && new_cnt == '0;
    assign entry_acc = (req_wait || !found) ? req_acc : ent_acc;
    assign wake_valid = state == WAKE;

    always_comb begin
        tab_en   = 1'b0;
        tab_we   = 1'b0;
        tab_addr = scan_idx;
        tab_din  = '0;
        if (clr_busy) begin
            tab_en   = 1'b1;
            tab_we   = 1'b1;
            tab_addr = clr_idx;
        end else if (state == SCAN_ADDR) begin
            tab_en = 1'b1;
        end else if (state == UPDATE && !imm_wake) begin
            tab_en   = 1'b1;
            tab_we   = 1'b1;
            tab_addr = found ? scan_idx : free_idx;
            // an entry whose count reached zero is written back as free
            tab_din[`TW_VALID_B] = !cnt_zero;
            tab_din[`TW_ACC_L+`TW_ACC_BITS-1:`TW_ACC_L] = entry_acc;
            tab_din[`TW_CNT_H:`TW_CNT_L] = new_cnt;
            tab_din[`TW_TID_H:`TW_TID_L] = req_tid;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state       <= IDLE;
            clr_started <= 1'b0;
            clr_busy    <= 1'b0;
            clr_idx     <= '0;
            last_wait   <= 1'b0;
        end else begin
            // one sweep over the table once reset is released
            if (!clr_started) begin
                clr_started <= 1'b1;
                clr_busy    <= 1'b1;
            end
            if (clr_busy) begin
                clr_idx <= clr_idx + 1'b1;
                if (clr_idx == LAST_IDX) begin
                    clr_busy <= 1'b0;
                end
            end
            case (state)
                IDLE: begin
                    if (start) begin
                        last_wait <= pick_wait;
                        state     <= READ_REQ;
                    end
                end
                READ_REQ:  state <= SCAN_ADDR;
                SCAN_ADDR: state <= SCAN_CMP;
                SCAN_CMP: begin
                    if (dout_match || scan_idx == LAST_IDX) begin
                        state <= UPDATE;
                    end else begin
                        state <= SCAN_ADDR;
                    end
                end
                UPDATE: state <= (imm_wake || cnt_zero) ? WAKE : IDLE;
                WAKE: begin
                    if (wake_ready) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            req_wait <= pick_wait ? wait_msg.is_wait : fin_msg.is_wait;
            req_comp <= pick_wait ? wait_msg.components : fin_msg.components;
            req_tid  <= pick_wait ? wait_msg.task_id : fin_msg.task_id;
            req_acc  <= pick_wait ? wait_msg.acc_id : fin_msg.acc_id;
        end
        if (state == READ_REQ) begin
            scan_idx   <= '0;
            free_found <= 1'b0;
            found      <= 1'b0;
        end
        if (state == SCAN_CMP) begin
            found   <= dout_match;
            ent_cnt <= tab_dout[`TW_CNT_H:`TW_CNT_L];
            ent_acc <= tab_dout[`TW_ACC_L+`TW_ACC_BITS-1:`TW_ACC_L];
            // remember the first free slot in case the id is not in the table
            if (!tab_dout[`TW_VALID_B] && !free_found) begin
                free_found <= 1'b1;
                free_idx   <= scan_idx;
            end
            if (!dout_match && scan_idx != LAST_IDX) begin
                scan_idx <= scan_idx + 1'b1;
            end
        end
        if (state == UPDATE) begin
            wake_dest <= entry_acc;
        end
    end

    assert property (@(posedge clk) disable iff (!rstn)
        state == UPDATE && !found && !imm_wake |-> free_found)
        else $error("taskwait table full, allocation without a free entry");

    assert property (@(posedge clk) disable iff (!rstn)
        wake_valid && !wake_ready |=> wake_valid && $stable(wake_dest))
        else $error("wake-up dropped or changed before wake_ready");

endmodule

// ==== tw_msg_decoder.sv ====
// holds one message at a time; a bad message code still consumes both beats and is dropped silently
`timescale 1ns/100ps
`include "tw_defines.svh"

module tw_msg_decoder import tw_pkg::*; (
    input  logic     clk,
    input  logic     rstn,
    input  task_id_t s_data,
    input  logic     s_valid,
    input  acc_id_t  s_src,
    output logic     s_ready,
    tw_msg_if.src    msg
);

    // low while waiting for a header beat, high while waiting for the task id beat
    logic id_phase;
    logic code_ok;
    logic hold_valid;
    logic hold_next;
    logic beat;

    assign beat = s_valid && s_ready;
    assign msg.msg_valid = hold_valid;

    // ready is low while holding, so a take and an accepted beat never meet
    always_comb begin
        hold_next = hold_valid;
        if (msg.msg_take) begin
            hold_next = 1'b0;
        end
        if (beat && id_phase && code_ok) begin
            hold_next = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            id_phase   <= 1'b0;
            hold_valid <= 1'b0;
            s_ready    <= 1'b0;
        end else begin
            hold_valid <= hold_next;
            s_ready    <= !hold_next;
            if (beat) begin
                id_phase <= !id_phase;
            end
        end
    end

    // header fields go straight into the message, since nothing is held while a header arrives
    always_ff @(posedge clk) begin
        if (beat && !id_phase) begin
            code_ok        <= s_data[`TW_CODE_H:`TW_CODE_L] == `TW_MSG_CODE;
            msg.is_wait    <= s_data[`TW_TYPE_BIT];
            msg.components <= s_data[`TW_COMP_H:`TW_COMP_L];
            msg.acc_id     <= s_src;
        end
        if (beat && id_phase && code_ok) begin
            msg.task_id <= s_data;
        end
    end

    // the engine latches the fields on take, so they must not move before it
    assert property (@(posedge clk) disable iff (!rstn)
        msg.msg_valid && !msg.msg_take |=>
            $stable({msg.is_wait, msg.components, msg.task_id, msg.acc_id}))
        else $error("decoded message changed before it was taken");

endmodule

// ==== tw_msg_if.sv ====
// one decoded message from a decoder to the engine; fields are only meaningful while msg_valid is high
`timescale 1ns/100ps

interface tw_msg_if import tw_pkg::*; ();

    logic     msg_valid;
    logic     msg_take;
    logic     is_wait;
    comp_t    components;
    task_id_t task_id;
    acc_id_t  acc_id;

    // the decoder holds the message until the engine pulses msg_take
    modport src (
        output msg_valid, is_wait, components, task_id, acc_id,
        input  msg_take
    );

    modport dst (
        input  msg_valid, is_wait, components, task_id, acc_id,
        output msg_take
    );

endinterface

// ==== tw_pkg.sv ====
// shared types for the taskwait manager; widths come from the defines header
`include "tw_defines.svh"

package tw_pkg;

    // accelerator id as carried by the stream source and wake-up destination
    typedef logic [`TW_ACC_BITS-1:0] acc_id_t;

    // parent task id, also the width of a stream data beat
    typedef logic [63:0] task_id_t;

    // component count in a request, and the signed pending count in the table
    typedef logic [31:0] comp_t;

    // index into the taskwait table
    typedef logic [$clog2(`TW_ENTRIES)-1:0] tw_idx_t;

    // one packed table entry
    typedef logic [`TW_WORD_W-1:0] tw_word_t;

    typedef enum logic [2:0] {
        IDLE,
        READ_REQ,
        SCAN_ADDR,
        SCAN_CMP,
        UPDATE,
        WAKE
    } tw_state_t;

endpackage

// ==== tw_table_ram.sv ====
// single port table memory, write-first, one cycle read latency, contents undefined until cleared
`timescale 1ns/100ps
`include "tw_defines.svh"

module tw_table_ram import tw_pkg::*; (
    input  logic     clk,
    input  logic     en,
    input  logic     we,
    input  tw_idx_t  addr,
    input  tw_word_t din,
    output tw_word_t dout
);

    tw_word_t mem [`TW_ENTRIES];

    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                mem[addr] <= din;
                // a write returns the new word on the read port
                dout <= din;
            end else begin
                dout <= mem[addr];
            end
        end
    end

endmodule

// ==== tw_top.sv ====
// taskwait manager top; each stream carries a header beat then a task id beat, src sampled on the header
`timescale 1ns/100ps

module tw_top import tw_pkg::*; (
    input  logic     clk,
    input  logic     rstn,
    input  task_id_t wait_data,
    input  logic     wait_valid,
    output logic     wait_ready,
    input  acc_id_t  wait_src,
    input  task_id_t fin_data,
    input  logic     fin_valid,
    output logic     fin_ready,
    input  acc_id_t  fin_src,
    output logic     wake_valid,
    input  logic     wake_ready,
    output acc_id_t  wake_dest
);

    tw_msg_if wait_if ();
    tw_msg_if fin_if ();

    logic     tab_en;
    logic     tab_we;
    tw_idx_t  tab_addr;
    tw_word_t tab_din;
    tw_word_t tab_dout;

    tw_msg_decoder u_wait_dec (
        .clk     (clk),
        .rstn    (rstn),
        .s_data  (wait_data),
        .s_valid (wait_valid),
        .s_src   (wait_src),
        .s_ready (wait_ready),
        .msg     (wait_if)
    );

    tw_msg_decoder u_fin_dec (
        .clk     (clk),
        .rstn    (rstn),
        .s_data  (fin_data),
        .s_valid (fin_valid),
        .s_src   (fin_src),
        .s_ready (fin_ready),
        .msg     (fin_if)
    );

    tw_engine u_engine (
        .clk        (clk),
        .rstn       (rstn),
        .wait_msg   (wait_if),
        .fin_msg    (fin_if),
        .tab_en     (tab_en),
        .tab_we     (tab_we),
        .tab_addr   (tab_addr),
        .tab_din    (tab_din),
        .tab_dout   (tab_dout),
        .wake_valid (wake_valid),
        .wake_ready (wake_ready),
        .wake_dest  (wake_dest)
    );

    tw_table_ram u_table (
        .clk  (clk),
        .en   (tab_en),
        .we   (tab_we),
        .addr (tab_addr),
        .din  (tab_din),
        .dout (tab_dout)
    );

endmodule
